//--- dv/sha256Model.svh
`ifndef SHA256_MODEL_SVH
`define SHA256_MODEL_SVH

// SHA-256 round words, FIPS 180-4 section 4.2.2
localparam word_t modelRoundWords [64] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
    32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
    32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
    32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
    32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
    32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
};

// H0 in the top word
localparam digest_t modelStartHash =
    256'h6a09e667_bb67ae85_3c6ef372_a54ff53a_510e527f_9b05688c_1f83d9ab_5be0cd19;

function automatic word_t rotateRight(input word_t value, input int amount);
    return (value >> amount) | (value << (32 - amount));
endfunction

// Whole 64-word schedule built up front, then 64 rounds
function automatic digest_t compressModel(input digest_t state, input block_t block);
    word_t w [64];
    word_t a, b, c, d, e, f, g, h;
    word_t s0, s1, t1, t2;
    for (int t = 0; t < 16; t++) begin
        w[t] = block[511 - 32 * t -: 32];
    end
    for (int t = 16; t < 64; t++) begin
        s0 = rotateRight(w[t-15], 7) ^ rotateRight(w[t-15], 18) ^ (w[t-15] >> 3);
        s1 = rotateRight(w[t-2], 17) ^ rotateRight(w[t-2], 19) ^ (w[t-2] >> 10);
        w[t] = w[t-16] + s0 + w[t-7] + s1;
    end
    {a, b, c, d, e, f, g, h} = state;
    for (int t = 0; t < 64; t++) begin
        s1 = rotateRight(e, 6) ^ rotateRight(e, 11) ^ rotateRight(e, 25);
        t1 = h + s1 + ((e & f) ^ (~e & g)) + modelRoundWords[t] + w[t];
        s0 = rotateRight(a, 2) ^ rotateRight(a, 13) ^ rotateRight(a, 22);
        t2 = s0 + ((a & b) ^ (a & c) ^ (b & c));
        h = g;
        g = f;
        f = e;
        e = d + t1;
        d = c;
        c = b;
        b = a;
        a = t1 + t2;
    end
    return {state[255:224] + a, state[223:192] + b, state[191:160] + c, state[159:128] + d,
            state[127:96] + e, state[95:64] + f, state[63:32] + g, state[31:0] + h};
endfunction

// SHA-256 of SHA-256 of the header, nonce field replaced
function automatic digest_t doubleHash(input header_t head, input word_t nonce);
    digest_t inner;
    inner = compressModel(modelStartHash, head[639:128]);
    // Tail, a one bit, zeros, then the 64-bit length 640
    inner = compressModel(inner, {head[127:32], nonce, 1'b1, 319'd0, 64'd640});
    // Digest padded as a 256-bit message
    return compressModel(modelStartHash, {inner, 1'b1, 191'd0, 64'd256});
endfunction

`endif

//--- dv/minerTb.sv
`default_nettype none

module minerTb;
    import minerPkg::*;

    localparam int MaxTries       = 64;
    localparam int ScanDivider    = 4;
    // Two first-nonce runs, six easy, two exhaustion, one wrap
    localparam int SearchCount    = 11;
    localparam int WatchdogCycles = SearchCount * MaxTries * 200 + 5000;
    // Core latency from start to done
    localparam int CompressCycles = 65;
    // Three compressions of start plus core latency, then the compare cycle
    localparam int NonceCycles    = 3 * (CompressCycles + 1) + 1;

    // Segment patterns gfedcba with lit segments at 0
    localparam segments_t segmentTable [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };

    logic      clock;
    logic      reset;
    logic      start;
    header_t   header;
    target_t   target;
    logic      busy;
    logic      found;
    logic      exhausted;
    word_t     foundNonce;
    digest_t   foundHash;
    logic      led;
    segments_t ca;
    logic      dp;
    logic [7:0] an;

    int          errorCount;
    logic        searchActive;
    logic [31:0] lfsrState;

    `include "sha256Model.svh"

    bitcoinMiner #(
        .MaxTries(MaxTries),
        .ScanDivider(ScanDivider)
    ) i_bitcoinMiner (
        .clock(clock),
        .reset(reset),
        .start(start),
        .header(header),
        .target(target),
        .busy(busy),
        .found(found),
        .exhausted(exhausted),
        .foundNonce(foundNonce),
        .foundHash(foundHash),
        .led(led),
        .ca(ca),
        .dp(dp),
        .an(an)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    // Taps 32 22 2 1 with one step per bit
    function automatic logic nextBit();
        logic feedback;
        feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [639:0] randomBits(input int count);
        logic [639:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value[i] = nextBit();
        end
        return value;
    endfunction

    // Exactly zeros leading zero bits and the rest random
    function automatic target_t easyTarget(input int zeros);
        target_t value;
        value = target_t'(randomBits(256)) >> zeros;
        return value | (target_t'(1) << (255 - zeros));
    endfunction

    task automatic reportError(input string message);
        errorCount++;
        $display("%s", message);
    endtask

    task automatic checkWord(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            errorCount++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkDigest(input string name, input digest_t expected, input digest_t actual);
        if (actual !== expected) begin
            errorCount++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkSegments(input string name, input segments_t expected,
                                 input segments_t actual);
        if (actual !== expected) begin
            errorCount++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errorCount++;
            $display("Fail %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic checkIdle(input string name);
        checkFlag({name, ".busy"}, 1'b0, busy);
        checkFlag({name, ".found"}, 1'b0, found);
        checkFlag({name, ".exhausted"}, 1'b0, exhausted);
        checkFlag({name, ".led"}, 1'b0, led);
        checkFlag({name, ".dp"}, 1'b1, dp);
        checkSegments({name, ".ca"}, 7'h7f, ca);
        if (an !== 8'hff) begin
            errorCount++;
            $display("Fail %s.an: expected ff, actual %h", name, an);
        end
    endtask

    // First nonce below target within MaxTries counting up with wrap
    task automatic predictSearch(input header_t head, input target_t limit, output logic hit,
                                 output word_t hitNonce, output digest_t hitHash);
        word_t   nonce;
        digest_t hash;
        hit      = 1'b0;
        hitNonce = '0;
        hitHash  = '0;
        nonce    = head[31:0];
        for (int i = 0; i < MaxTries && !hit; i++) begin
            hash = doubleHash(head, nonce);
            if (hash < limit) begin
                hit      = 1'b1;
                hitNonce = nonce;
                hitHash  = hash;
            end else begin
                nonce = nonce + 32'd1;
            end
        end
    endtask

    // One search with an optional second start at cycle secondStartAt (0 for none)
    task automatic runSearch(input string name, input header_t head, input target_t limit,
                             input int secondStartAt, output logic hit,
                             output word_t hitNonce, output int latency);
        digest_t hitHash;
        int      cycles;
        logic    ended;
        predictSearch(head, limit, hit, hitNonce, hitHash);
        @(posedge clock);
        #1;
        header       = head;
        target       = limit;
        start        = 1'b1;
        searchActive = 1'b1;
        cycles       = 0;
        ended        = 1'b0;
        while (!ended) begin
            @(posedge clock);
            #1;
            cycles++;
            start = (cycles == secondStartAt);
            @(negedge clock);
            if (cycles == 1) begin
                checkFlag({name, ".busyAfterStart"}, 1'b1, busy);
                checkFlag({name, ".ledAfterStart"}, 1'b0, led);
            end
            ended = found || exhausted;
        end
        start   = 1'b0;
        latency = cycles;
        // busy drops in the pulse cycle
        checkFlag({name, ".busyAtEnd"}, 1'b0, busy);
        if (found && exhausted) begin
            reportError({name, ": found and exhausted pulsed together"});
        end else if (hit && !found) begin
            reportError({name, ": search gave up although a passing nonce exists"});
        end else if (!hit && found) begin
            reportError({name, ": found pulsed although no nonce passes"});
        end else if (found) begin
            checkWord({name, ".foundNonce"}, hitNonce, foundNonce);
            checkDigest({name, ".foundHash"}, hitHash, foundHash);
        end
        @(negedge clock);
        if (found || exhausted) begin
            reportError({name, ": result pulse lasted more than one cycle"});
        end
        searchActive = 1'b0;
    endtask

    // Two full scan rounds with each selected digit checked against the nonce
    task automatic checkDisplay(input string name, input word_t nonce);
        logic [7:0] seen;
        int         digit;
        seen = '0;
        checkFlag({name, ".led"}, 1'b1, led);
        repeat (16 * ScanDivider) begin
            @(negedge clock);
            checkFlag({name, ".ledHeld"}, 1'b1, led);
            if ($countones(~an) != 1) begin
                reportError({name, ": anode lines do not select exactly one digit"});
            end else begin
                digit = 0;
                for (int i = 0; i < 8; i++) begin
                    if (!an[i]) begin
                        digit = i;
                    end
                end
                seen[digit] = 1'b1;
                checkSegments({name, ".ca"}, segmentTable[nonce[4 * digit +: 4]], ca);
                checkFlag({name, ".dp"}, 1'b1, dp);
            end
        end
        if (seen != 8'hff) begin
            reportError({name, ": not every digit was scanned"});
        end
    endtask

    // Pulses only belong inside a search
    always @(negedge clock) begin
        if (!reset && !searchActive && (found || exhausted)) begin
            reportError("Result pulse seen while no search was running");
        end
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clock);
        if (busy) begin
            $display("Watchdog expired with busy still high");
        end else begin
            $display("Watchdog expired before the test sequence finished");
        end
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        header_t head;
        target_t limit;
        logic    hit;
        word_t   hitNonce;
        int      latency;
        int      repeatLatency;
        int      singleLatency;
        logic    wrapReady;
        digest_t unusedHash;
        errorCount   = 0;
        searchActive = 1'b0;
        lfsrState    = 32'hc323_1baf;
        reset        = 1'b1;
        start        = 1'b0;
        header       = '0;
        target       = '0;
        repeat (2) @(negedge clock);
        checkIdle("inReset");
        repeat (6) @(posedge clock);
        #1;
        reset = 1'b0;
        @(negedge clock);
        checkIdle("afterReset");

        // All-ones target lets the start nonce pass at once
        head  = header_t'(randomBits(640));
        limit = '1;
        runSearch("allOnes", head, limit, 0, hit, hitNonce, latency);
        checkWord("allOnes.startNonce", head[31:0], foundNonce);
        singleLatency = latency;
        checkDisplay("allOnesDisplay", hitNonce);

        // Same search with a start pulse mid-way
        runSearch("ignoredStart", head, limit, 100, hit, hitNonce, repeatLatency);
        if (repeatLatency != latency) begin
            reportError("Start pulse while busy changed the search length");
        end

        for (int i = 0; i < 6; i++) begin
            head  = header_t'(randomBits(640));
            limit = easyTarget(3 + int'(randomBits(2)) % 3);
            runSearch($sformatf("easy%0d", i), head, limit, 0, hit, hitNonce, latency);
            if (hit) begin
                checkDisplay($sformatf("easy%0dDisplay", i), hitNonce);
            end
        end

        // Zero target never passes
        head  = header_t'(randomBits(640));
        limit = '0;
        runSearch("exhaust", head, limit, 0, hit, hitNonce, latency);
        checkFlag("exhaust.led", 1'b0, led);
        // All MaxTries nonces tried, one more than the single-nonce search
        if (latency - singleLatency != (MaxTries - 1) * NonceCycles) begin
            reportError("Exhaustion did not come after trying exactly MaxTries nonces");
        end
        runSearch("exhaustIgnoredStart", head, limit, 5000, hit, hitNonce, repeatLatency);
        if (repeatLatency != latency) begin
            reportError("Start pulse while busy changed the exhaustion length");
        end
        checkFlag("exhaustIgnoredStart.led", 1'b0, led);

        // Pick a header whose first passing nonce lies past the wrap
        wrapReady = 1'b0;
        for (int attempt = 0; attempt < 20 && !wrapReady; attempt++) begin
            head        = header_t'(randomBits(640));
            head[31:0]  = 32'hffff_fffc - word_t'(randomBits(2));
            limit       = easyTarget(3);
            predictSearch(head, limit, hit, hitNonce, unusedHash);
            wrapReady   = hit && (hitNonce < head[31:0]);
        end
        if (!wrapReady) begin
            reportError("No header found whose search crosses the nonce wrap");
        end
        runSearch("wrap", head, limit, 0, hit, hitNonce, latency);
        if (hit) begin
            checkDisplay("wrapDisplay", hitNonce);
        end

        repeat (4) @(posedge clock);
        $display("Checks finished with %0d errors", errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module minerTb -f src.f -o minerSim \
    && ./obj_dir/minerSim | tee sim.log \
    && grep -qx "TEST PASSED" sim.log \
    && echo "Simulation run succeeded" \
    || { echo "Simulation run did not succeed"; exit 1; }

//--- src.f
+incdir+dv
verilog/minerPkg.sv
verilog/sha256Compress.sv
verilog/minerControl.sv
verilog/nonceDisplay.sv
verilog/bitcoinMiner.sv
dv/minerTb.sv

//--- verilog/bitcoinMiner.sv
`default_nettype none

module bitcoinMiner #(
    parameter int MaxTries    = 64,
    parameter int ScanDivider = 4
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                start,
    input  minerPkg::header_t   header,
    input  minerPkg::target_t   target,
    output logic                busy,
    output logic                found,
    output logic                exhausted,
    output minerPkg::word_t     foundNonce,
    output minerPkg::digest_t   foundHash,
    output logic                led,
    output minerPkg::segments_t ca,
    output logic                dp,
    output logic [7:0]          an
);
    import minerPkg::*;

    // Sequencer to compression core
    logic    compressStart;
    block_t  compressBlock;
    digest_t compressState;
    logic    compressDone;
    digest_t compressDigest;

    minerControl #(
        .MaxTries(MaxTries)
    ) i_minerControl (
        .clock(clock),
        .reset(reset),
        .start(start),
        .header(header),
        .target(target),
        .compressStart(compressStart),
        .compressBlock(compressBlock),
        .compressState(compressState),
        .compressDone(compressDone),
        .compressDigest(compressDigest),
        .busy(busy),
        .found(found),
        .exhausted(exhausted),
        .foundNonce(foundNonce),
        .foundHash(foundHash)
    );

    // Shared by all three hashes of a nonce
    sha256Compress i_sha256Compress (
        .clock(clock),
        .reset(reset),
        .compressStart(compressStart),
        .compressBlock(compressBlock),
        .compressState(compressState),
        .compressDone(compressDone),
        .compressDigest(compressDigest)
    );

    nonceDisplay #(
        .ScanDivider(ScanDivider)
    ) i_nonceDisplay (
        .clock(clock),
        .reset(reset),
        .start(start),
        .found(found),
        .foundNonce(foundNonce),
        .led(led),
        .ca(ca),
        .dp(dp),
        .an(an)
    );

endmodule

`default_nettype wire

//--- verilog/minerControl.sv
`default_nettype none

module minerControl #(
    parameter int MaxTries = 64
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              start,
    input  minerPkg::header_t header,
    input  minerPkg::target_t target,
    output logic              compressStart,
    output minerPkg::block_t  compressBlock,
    output minerPkg::digest_t compressState,
    input  logic              compressDone,
    input  minerPkg::digest_t compressDigest,
    output logic              busy,
    output logic              found,
    output logic              exhausted,
    output minerPkg::word_t   foundNonce,
    output minerPkg::digest_t foundHash
);
    import minerPkg::*;

    // Message lengths in bits for the padding tail
    localparam logic [63:0] HeaderLength = 64'd640;
    localparam logic [63:0] DigestLength = 64'd256;

    minerState_t state;
    word_t       nonce;
    word_t       tries;
    // First-pass digest, midstate then inner hash
    digest_t     chainDigest;
    logic        hashBelowTarget;
    logic        lastTry;

    assign busy            = (state != idle);
    assign hashBelowTarget = (compressDigest < target);
    assign lastTry         = (tries == word_t'(MaxTries - 1));

    // Block and chaining state for the core, sampled on compressStart
    always_comb begin
        case (state)
            secondBlock: begin
                // Header tail with the live nonce, then 640-bit padding
                compressBlock = {header[127:32], nonce, 1'b1, 319'd0, HeaderLength};
                compressState = chainDigest;
            end
            digestBlock: begin
                // Inner hash padded as a 256-bit message
                compressBlock = {chainDigest, 1'b1, 191'd0, DigestLength};
                compressState = initialHash;
            end
            default: begin
                compressBlock = header[639:128];
                compressState = initialHash;
            end
        endcase
    end

    // Sequencer
    always_ff @(posedge clock) begin
        if (reset) begin
            state         <= idle;
            tries         <= '0;
            compressStart <= 1'b0;
            found         <= 1'b0;
            exhausted     <= 1'b0;
        end else begin
            compressStart <= 1'b0;
            found         <= 1'b0;
            exhausted     <= 1'b0;
            case (state)
                idle: begin
                    // Start only honoured when idle
                    if (start) begin
                        state         <= firstBlock;
                        tries         <= '0;
                        compressStart <= 1'b1;
                    end
                end
                firstBlock: begin
                    if (compressDone) begin
                        state         <= secondBlock;
                        compressStart <= 1'b1;
                    end
                end
                secondBlock: begin
                    if (compressDone) begin
                        state         <= digestBlock;
                        compressStart <= 1'b1;
                    end
                end
                digestBlock: begin
                    if (compressDone) begin
                        state <= compare;
                    end
                end
                compare: begin
                    if (hashBelowTarget) begin
                        state <= idle;
                        found <= 1'b1;
                    end else if (lastTry) begin
                        state     <= idle;
                        exhausted <= 1'b1;
                    end else begin
                        // Next nonce, header blocks rehashed from scratch
                        state         <= firstBlock;
                        tries         <= tries + 32'd1;
                        compressStart <= 1'b1;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Nonce, intermediate digest and results
    always_ff @(posedge clock) begin
        if (state == idle && start) begin
            // Search begins at the header's own nonce
            nonce <= header[31:0];
        end
        if (compressDone && (state == firstBlock || state == secondBlock)) begin
            chainDigest <= compressDigest;
        end
        if (state == compare) begin
            if (hashBelowTarget) begin
                foundNonce <= nonce;
                foundHash  <= compressDigest;
            end else begin
                // Wraps past all ones
                nonce <= nonce + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/minerPkg.sv
`default_nettype none

package minerPkg;

    // Basic SHA-256 quantities
    typedef logic [31:0]  word_t;
    typedef logic [511:0] block_t;
    typedef logic [255:0] digest_t;

    // Block header, nonce lives in bits [31:0]
    typedef logic [639:0] header_t;
    typedef logic [255:0] target_t;

    // Seven-segment pattern gfedcba, active low
    typedef logic [6:0]   segments_t;

    // Nonce search sequencer states
    typedef enum logic [2:0] {
        idle,
        firstBlock,
        secondBlock,
        digestBlock,
        compare
    } minerState_t;

    // Round constants K0..K63
    localparam word_t roundConstants [64] = '{
        32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
        32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
        32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
        32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
        32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
        32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
        32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
        32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
        32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
        32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
        32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
        32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
        32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
        32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
        32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
        32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
    };

    // H0..H7, H0 in the top word
    localparam digest_t initialHash =
        256'h6a09e667_bb67ae85_3c6ef372_a54ff53a_510e527f_9b05688c_1f83d9ab_5be0cd19;

    // Hex digit to segments, lit segment is 0
    function automatic segments_t hexToSegments(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h10;
            4'ha: return 7'h08;
            4'hb: return 7'h03;
            4'hc: return 7'h46;
            4'hd: return 7'h21;
            4'he: return 7'h06;
            default: return 7'h0e;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- verilog/nonceDisplay.sv
`default_nettype none

module nonceDisplay #(
    parameter int ScanDivider = 4
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                start,
    input  logic                found,
    input  minerPkg::word_t     foundNonce,
    output logic                led,
    output minerPkg::segments_t ca,
    output logic                dp,
    output logic [7:0]          an
);
    import minerPkg::*;

    localparam int PrescaleWidth = $clog2(ScanDivider + 1);

    word_t                    shownNonce;
    logic                     ledFlag;
    logic [PrescaleWidth-1:0] prescale;
    logic [2:0]               digitIndex;
    logic [3:0]               nibble;

    // Result flag, start clears it
    always_ff @(posedge clock) begin
        if (reset) begin
            ledFlag <= 1'b0;
        end else if (found) begin
            ledFlag <= 1'b1;
        end else if (start) begin
            ledFlag <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (found) begin
            shownNonce <= foundNonce;
        end
    end

    // Digit scan timing
    always_ff @(posedge clock) begin
        if (reset) begin
            prescale   <= '0;
            digitIndex <= 3'd0;
        end else if (prescale == PrescaleWidth'(ScanDivider - 1)) begin
            prescale   <= '0;
            digitIndex <= digitIndex + 3'd1;
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

    // Digit 0 is the low nibble
    assign nibble = shownNonce[4 * digitIndex +: 4];

    // Blank until a nonce has been found
    assign an  = ledFlag ? ~(8'b1 << digitIndex) : 8'hff;
    assign ca  = ledFlag ? hexToSegments(nibble) : 7'h7f;
    // Decimal point unused, kept dark
    assign dp  = 1'b1;
    assign led = ledFlag;

endmodule

`default_nettype wire

//--- verilog/sha256Compress.sv
`default_nettype none

module sha256Compress (
    input  logic              clock,
    input  logic              reset,
    input  logic              compressStart,
    input  minerPkg::block_t  compressBlock,
    input  minerPkg::digest_t compressState,
    output logic              compressDone,
    output minerPkg::digest_t compressDigest
);
    import minerPkg::*;

    // Sliding window, schedule[0] is W[t] of the current round
    word_t      schedule [16];
    // Working variables a..h
    word_t      work [8];
    word_t      nextWork [8];
    // Chaining state kept for the final addition
    digest_t    savedState;
    logic [5:0] round;
    logic       running;

    word_t      bigSigma0;
    word_t      bigSigma1;
    word_t      choose;
    word_t      majority;
    word_t      temp1;
    word_t      temp2;
    word_t      sigma0;
    word_t      sigma1;
    word_t      newWord;

    function automatic word_t rotr(input word_t value, input int amount);
        return (value >> amount) | (value << (32 - amount));
    endfunction

    // One SHA-256 round
    always_comb begin
        bigSigma1 = rotr(work[4], 6) ^ rotr(work[4], 11) ^ rotr(work[4], 25);
        choose    = (work[4] & work[5]) ^ (~work[4] & work[6]);
        temp1     = work[7] + bigSigma1 + choose + roundConstants[round] + schedule[0];
        bigSigma0 = rotr(work[0], 2) ^ rotr(work[0], 13) ^ rotr(work[0], 22);
        majority  = (work[0] & work[1]) ^ (work[0] & work[2]) ^ (work[1] & work[2]);
        temp2     = bigSigma0 + majority;

        // Shift the variables down, a and e get the new values
        nextWork[0] = temp1 + temp2;
        nextWork[1] = work[0];
        nextWork[2] = work[1];
        nextWork[3] = work[2];
        nextWork[4] = work[3] + temp1;
        nextWork[5] = work[4];
        nextWork[6] = work[5];
        nextWork[7] = work[6];
    end

    // Message expansion, yields W[t+16]
    always_comb begin
        sigma0  = rotr(schedule[1], 7) ^ rotr(schedule[1], 18) ^ (schedule[1] >> 3);
        sigma1  = rotr(schedule[14], 17) ^ rotr(schedule[14], 19) ^ (schedule[14] >> 10);
        newWord = sigma1 + schedule[9] + sigma0 + schedule[0];
    end

    // Round sequencing
    always_ff @(posedge clock) begin
        if (reset) begin
            running      <= 1'b0;
            round        <= 6'd0;
            compressDone <= 1'b0;
        end else begin
            compressDone <= 1'b0;
            if (compressStart) begin
                running <= 1'b1;
                round   <= 6'd0;
            end else if (running) begin
                round <= round + 6'd1;
                // Last round, digest written in the same edge
                if (round == 6'd63) begin
                    running      <= 1'b0;
                    compressDone <= 1'b1;
                end
            end
        end
    end

    // Datapath registers
    always_ff @(posedge clock) begin
        if (compressStart) begin
            savedState <= compressState;
            // Word 0 sits in the top bits of the block
            for (int i = 0; i < 16; i++) begin
                schedule[i] <= compressBlock[511 - 32 * i -: 32];
            end
            for (int i = 0; i < 8; i++) begin
                work[i] <= compressState[255 - 32 * i -: 32];
            end
        end else if (running) begin
            for (int i = 0; i < 15; i++) begin
                schedule[i] <= schedule[i + 1];
            end
            schedule[15] <= newWord;
            work         <= nextWork;
            // Feed-forward add of the chaining state
            if (round == 6'd63) begin
                for (int i = 0; i < 8; i++) begin
                    compressDigest[255 - 32 * i -: 32] <=
                        savedState[255 - 32 * i -: 32] + nextWork[i];
                end
            end
        end
    end

endmodule

`default_nettype wire
